// File: all.f
hdl/lc3b_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_forward.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/write_back_stage.sv
hdl/cpu_datapath.sv
verif/tb_mem_model.sv
verif/tb_cpu.sv

// File: Makefile
TOP = tb_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module cpu_datapath

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verif/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

localparam int num_instr = 200;
localparam lc3b_pkg::lc3b_word loop_pc = 16'd400;

/* The shadows of the last four branches and the real fetch reach the loop address
   at most five times before the self-branch retires. */
localparam int loop_done_fetches = 6;

typedef struct packed {
	lc3b_pkg::lc3b_word address;
	lc3b_pkg::lc3b_word data;
} write_t;

typedef struct packed {
	logic stb;
	logic cyc;
	logic write;
	lc3b_pkg::lc3b_word address;
	lc3b_pkg::lc3b_word wdata;
} port_t;

logic clk;
logic reset;
lc3b_pkg::lc3b_word imem_rdata;
logic imem_resp;
lc3b_pkg::lc3b_word imem_address;
logic imem_action_stb;
logic imem_action_cyc;
lc3b_pkg::lc3b_word dmem_rdata;
logic dmem_resp;
lc3b_pkg::lc3b_word dmem_address;
lc3b_pkg::lc3b_word dmem_wdata;
logic dmem_write;
logic dmem_action_stb;
logic dmem_action_cyc;

integer seed;
integer errors;
integer writes_seen;
integer writes_expected;
integer loop_fetches;
lc3b_pkg::lc3b_word program_words [num_instr + 1];
write_t expected [$];
logic prev_reset;
port_t prev_i;
port_t prev_d;
logic prev_iresp;
logic prev_dresp;
port_t cur_i;
port_t cur_d;

cpu_datapath DUT (
	.clk(clk), .reset(reset),
	.imem_rdata(imem_rdata), .imem_resp(imem_resp), .imem_address(imem_address),
	.imem_action_stb(imem_action_stb), .imem_action_cyc(imem_action_cyc),
	.dmem_rdata(dmem_rdata), .dmem_resp(dmem_resp), .dmem_address(dmem_address),
	.dmem_wdata(dmem_wdata), .dmem_write(dmem_write),
	.dmem_action_stb(dmem_action_stb), .dmem_action_cyc(dmem_action_cyc)
);

tb_mem_model imem_model (
	.clk(clk), .reset(reset), .address(imem_address), .stb(imem_action_stb),
	.cyc(imem_action_cyc), .write(1'b0), .wdata(16'h0000),
	.rdata(imem_rdata), .resp(imem_resp)
);

tb_mem_model dmem_model (
	.clk(clk), .reset(reset), .address(dmem_address), .stb(dmem_action_stb),
	.cyc(dmem_action_cyc), .write(dmem_write), .wdata(dmem_wdata),
	.rdata(dmem_rdata), .resp(dmem_resp)
);

always #2 clk = ~clk;

// The initial data memory word is a scramble of its full address.
function automatic lc3b_pkg::lc3b_word fill_word(input lc3b_pkg::lc3b_word addr);
	return (addr * 16'h2f3b) ^ 16'h96c5 ^ {addr[7:0], addr[15:8]};
endfunction

function automatic logic [2:0] cc_of(input lc3b_pkg::lc3b_word value);
	if (value[15])
		return 3'b100;
	else if (value == 16'h0000)
		return 3'b010;
	return 3'b001;
endfunction

/**************************************************/
/* Program generator and ISA model                */
/**************************************************/

/* Registers r0 to r3 carry data and r7 stays zero as the load and store base. */
task automatic build_program();
	logic [15:0] r;
	logic [15:0] s;
	logic [8:0] off;
	for (int i = 0; i < num_instr; i++) begin
		r = 16'($random(seed));
		s = 16'($random(seed));
		case (r[2:0])
			3'd0, 3'd1, 3'd2: begin
				if (r[3])
					program_words[i] = {(r[0] ? lc3b_pkg::op_and : lc3b_pkg::op_add),
					                    1'b0, s[1:0], 1'b0, s[3:2], 1'b1, s[10:6]};
				else
					program_words[i] = {(r[0] ? lc3b_pkg::op_and : lc3b_pkg::op_add),
					                    1'b0, s[1:0], 1'b0, s[3:2], 3'b000, 1'b0, s[5:4]};
			end
			3'd3: program_words[i] = {lc3b_pkg::op_not, 1'b0, s[1:0], 1'b0, s[3:2], 6'b111111};
			3'd4: program_words[i] = {lc3b_pkg::op_ldr, 1'b0, s[1:0], 3'd7, s[15:10]};
			3'd5, 3'd6: program_words[i] = {lc3b_pkg::op_str, 1'b0, s[1:0], 3'd7, s[15:10]};
			default: begin
				off = {7'd0, r[8:7]};
				if (int'(off) > num_instr - 1 - i)
					off = 9'(num_instr - 1 - i);
				program_words[i] = {lc3b_pkg::op_br, r[6:4], off};
			end
		endcase
	end
	program_words[num_instr] = {lc3b_pkg::op_br, 3'b111, 9'h1ff};
endtask

task automatic run_golden();
	lc3b_pkg::lc3b_word regs [8];
	lc3b_pkg::lc3b_word gmem [lc3b_pkg::lc3b_word];
	lc3b_pkg::lc3b_word pc;
	lc3b_pkg::lc3b_word instr;
	lc3b_pkg::lc3b_word b;
	lc3b_pkg::lc3b_word addr;
	lc3b_pkg::lc3b_opcode op;
	logic [2:0] cc;
	integer steps;
	for (int i = 0; i < 8; i++)
		regs[i] = 16'h0000;
	pc = 16'h0000;
	cc = 3'b010;
	steps = 0;
	while (pc != loop_pc && steps < 10 * num_instr) begin
		instr = program_words[pc[15:1]];
		op = lc3b_pkg::lc3b_opcode'(instr[15:12]);
		pc = pc + 16'd2;
		steps++;
		b = instr[5] ? {{11{instr[4]}}, instr[4:0]} : regs[instr[2:0]];
		addr = regs[instr[8:6]] + {{9{instr[5]}}, instr[5:0], 1'b0};
		case (op)
			lc3b_pkg::op_add: regs[instr[11:9]] = regs[instr[8:6]] + b;
			lc3b_pkg::op_and: regs[instr[11:9]] = regs[instr[8:6]] & b;
			lc3b_pkg::op_not: regs[instr[11:9]] = ~regs[instr[8:6]];
			lc3b_pkg::op_ldr:
				regs[instr[11:9]] = gmem.exists(addr) ? gmem[addr] : fill_word(addr);
			lc3b_pkg::op_str: begin
				gmem[addr] = regs[instr[11:9]];
				expected.push_back({addr, regs[instr[11:9]]});
			end
			lc3b_pkg::op_br:
				if ((instr[11:9] & cc) != 3'b000)
					pc = pc + {{6{instr[8]}}, instr[8:0], 1'b0};
			default: ;
		endcase
		if (op == lc3b_pkg::op_add || op == lc3b_pkg::op_and ||
		    op == lc3b_pkg::op_not || op == lc3b_pkg::op_ldr)
			cc = cc_of(regs[instr[11:9]]);
	end
	writes_expected = expected.size();
endtask

/**************************************************/
/* Monitors                                       */
/**************************************************/

assign cur_i = {imem_action_stb, imem_action_cyc, 1'b0, imem_address, 16'h0000};
assign cur_d = {dmem_action_stb, dmem_action_cyc, dmem_write, dmem_address, dmem_wdata};

always @(posedge clk) begin : monitor
	write_t exp_w;
	write_t act_w;
	if (prev_reset) begin
		assert (!dmem_action_stb) else begin
			errors++;
			$display("dmem strobe high during or right after reset");
		end
	end
	if (prev_reset && !reset) begin
		assert (imem_action_stb && imem_address == 16'h0000) else begin
			errors++;
			$display("CHECK FAILED first_fetch expected %h actual %h", 16'h0000, imem_address);
		end
	end
	if (!reset && !prev_reset) begin
		assert (!(prev_i.stb && !prev_iresp) || cur_i == prev_i) else begin
			errors++;
			$display("CHECK FAILED imem_hold expected %h actual %h", prev_i, cur_i);
		end
		assert (!(prev_d.stb && !prev_dresp) || cur_d == prev_d) else begin
			errors++;
			$display("CHECK FAILED dmem_hold expected %h actual %h", prev_d, cur_d);
		end
	end
	if (!reset && dmem_action_stb && dmem_resp && dmem_write) begin
		writes_seen++;
		act_w = {dmem_address, dmem_wdata};
		assert (expected.size() != 0) else begin
			errors++;
			$display("data write to %h that the program never makes", dmem_address);
		end
		if (expected.size() != 0) begin
			exp_w = expected.pop_front();
			assert (act_w == exp_w) else begin
				errors++;
				$display("CHECK FAILED data_write expected %h/%h actual %h/%h",
				         exp_w.address, exp_w.data, act_w.address, act_w.data);
			end
		end
	end
	if (!reset && imem_action_stb && imem_resp && imem_address == loop_pc)
		loop_fetches++;
	prev_reset <= reset;
	prev_i <= cur_i;
	prev_d <= cur_d;
	prev_iresp <= imem_resp;
	prev_dresp <= dmem_resp;
end

initial begin : watchdog
	#(num_instr * 60 * 4);
	$display("timeout: the program never reached its final loop");
	$display("TEST RESULT: FAIL");
	$finish;
end

initial begin
	clk = 1'b0;
	reset = 1'b1;
	seed = 71;
	errors = 0;
	writes_seen = 0;
	loop_fetches = 0;
	prev_reset = 1'b0;
	prev_i = '0;
	prev_d = '0;
	prev_iresp = 1'b0;
	prev_dresp = 1'b0;
	build_program();
	for (int i = 0; i < 32768; i++) begin
		dmem_model.mem[i] = fill_word(16'(2 * i));
		imem_model.mem[i] = (i <= num_instr) ? program_words[i] : lc3b_pkg::nop_instruction;
	end
	run_golden();
	repeat (3) @(negedge clk);
	reset = 1'b0;
	// Only a redirect by the retired self-branch can fetch the loop address this often.
	wait (loop_fetches >= loop_done_fetches);
	@(negedge clk);
	assert (writes_seen == writes_expected) else begin
		errors++;
		$display("CHECK FAILED write_count expected %0d actual %0d",
		         writes_expected, writes_seen);
	end
	$display("errors=%0d writes=%0d expected_writes=%0d", errors, writes_seen,
	         writes_expected);
	if (errors == 0) begin
		$display("TEST RESULT: PASS");
	end else begin
		$display("TEST RESULT: FAIL");
	end
	$finish;
end

endmodule: tb_cpu

// File: verif/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model
(
	input logic clk,
	input logic reset,
	input lc3b_pkg::lc3b_word address,
	input logic stb,
	input logic cyc,
	input logic write,
	input lc3b_pkg::lc3b_word wdata,
	output lc3b_pkg::lc3b_word rdata,
	output logic resp
);

/* The testbench fills one word per even byte address. */
lc3b_pkg::lc3b_word mem [32768];
integer seed;
integer wait_left;

initial begin
	seed = 71;
	wait_left = -1;
	rdata = '0;
	resp = 1'b0;
end

/* The response is given for one cycle after 0 to 5 wait cycles. */
always @(negedge clk) begin : respond
	integer w;
	if (reset) begin
		resp <= 1'b0;
		wait_left = -1;
	end else if (resp) begin
		resp <= 1'b0;
	end else if (stb && cyc) begin
		w = wait_left;
		if (w < 0)
			w = $unsigned($random(seed)) % 6;
		if (w == 0) begin
			resp <= 1'b1;
			if (write)
				mem[address[15:1]] <= wdata;
			else
				rdata <= mem[address[15:1]];
			wait_left = -1;
		end else begin
			wait_left = w - 1;
		end
	end
end

endmodule: tb_mem_model

// File: hdl/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath
(
	input logic clk,
	input logic reset,

	/* Instruction memory port */
	input lc3b_pkg::lc3b_word imem_rdata,
	input logic imem_resp,
	output lc3b_pkg::lc3b_word imem_address,
	output logic imem_action_stb,
	output logic imem_action_cyc,

	/* Data memory port */
	input lc3b_pkg::lc3b_word dmem_rdata,
	input logic dmem_resp,
	output lc3b_pkg::lc3b_word dmem_address,
	output lc3b_pkg::lc3b_word dmem_wdata,
	output logic dmem_write,
	output logic dmem_action_stb,
	output logic dmem_action_cyc
);

lc3b_pkg::if_id_t fetch_out;
lc3b_pkg::if_id_t if_id;
lc3b_pkg::id_ex_t decoded;
lc3b_pkg::id_ex_t id_ex;
lc3b_pkg::ex_mem_t executed;
lc3b_pkg::ex_mem_t ex_mem;
lc3b_pkg::ex_mem_t ex_mem_live;
lc3b_pkg::mem_wb_t mem_out;
lc3b_pkg::mem_wb_t mem_wb;

logic advance;
logic load_use;
logic mem_stall;
logic branch_enable;
logic [1:0] sr1_forward_sel;
logic [1:0] sr2_forward_sel;
lc3b_pkg::lc3b_word write_data;
lc3b_pkg::lc3b_reg write_register;
logic load_regfile;

assign advance = fetch_out.valid && !mem_stall && !load_use;
assign write_register = mem_wb.dest;
assign load_regfile = mem_wb.ctrl.valid && mem_wb.ctrl.load_regfile;

/* A taken branch kills the EX/MEM entry before it can touch data memory. */
always_comb begin
	ex_mem_live = ex_mem;
	if (branch_enable)
		ex_mem_live.ctrl.valid = 1'b0;
end

fetch_stage if_stage
(
	.clk(clk),
	.reset(reset),
	.advance(advance),
	.branch_enable(branch_enable),
	.branch_target(mem_wb.branch_target),
	.imem_rdata(imem_rdata),
	.imem_resp(imem_resp),
	.imem_address(imem_address),
	.imem_action_stb(imem_action_stb),
	.imem_action_cyc(imem_action_cyc),
	.fetch_out(fetch_out)
);

decode_stage id_stage
(
	.clk(clk),
	.reset(reset),
	.if_id(if_id),
	.write_register(write_register),
	.write_data(write_data),
	.load_regfile(load_regfile),
	.decoded(decoded)
);

execute_forward ex_forward
(
	.id_ex(id_ex),
	.ex_mem(ex_mem),
	.mem_wb(mem_wb),
	.sr1_forward_sel(sr1_forward_sel),
	.sr2_forward_sel(sr2_forward_sel),
	.load_use(load_use)
);

execute_stage ex_stage
(
	.id_ex(id_ex),
	.ex_mem_result(ex_mem.alu_result),
	.wb_result(write_data),
	.sr1_forward_sel(sr1_forward_sel),
	.sr2_forward_sel(sr2_forward_sel),
	.executed(executed)
);

memory_stage mem_stage
(
	.clk(clk),
	.reset(reset),
	.ex_mem(ex_mem_live),
	.advance(advance),
	.dmem_rdata(dmem_rdata),
	.dmem_resp(dmem_resp),
	.dmem_address(dmem_address),
	.dmem_wdata(dmem_wdata),
	.dmem_write(dmem_write),
	.dmem_action_stb(dmem_action_stb),
	.dmem_action_cyc(dmem_action_cyc),
	.mem_stall(mem_stall),
	.mem_out(mem_out)
);

write_back_stage wb_stage
(
	.clk(clk),
	.reset(reset),
	.mem_wb(mem_wb),
	.write_data(write_data),
	.branch_enable(branch_enable)
);

/**************************************************/
/* Pipeline registers                             */
/**************************************************/

always_ff @(posedge clk) begin
	if (reset) begin
		if_id.valid <= 1'b0;
		if_id.instruction <= lc3b_pkg::nop_instruction;
	end else if (branch_enable) begin
		if_id.valid <= 1'b0;
	end else if (advance) begin
		if_id <= fetch_out;
	end
end

/* A held ID/EX entry picks up write-backs it would otherwise miss. */
always_ff @(posedge clk) begin
	if (reset) begin
		id_ex.ctrl.valid <= 1'b0;
	end else if (branch_enable) begin
		id_ex.ctrl.valid <= 1'b0;
	end else if (advance) begin
		id_ex <= decoded;
	end else if (load_regfile) begin
		if (write_register == id_ex.sr1)
			id_ex.sr1_value <= write_data;
		if (write_register == id_ex.sr2)
			id_ex.sr2_value <= write_data;
	end
end

/* When only MEM/WB moves, EX/MEM is left holding a bubble. */
always_ff @(posedge clk) begin
	if (reset) begin
		ex_mem.ctrl.valid <= 1'b0;
	end else if (branch_enable) begin
		ex_mem.ctrl.valid <= 1'b0;
	end else if (advance) begin
		ex_mem <= executed;
	end else if (!mem_stall) begin
		ex_mem.ctrl.valid <= 1'b0;
	end
end

always_ff @(posedge clk) begin
	if (reset) begin
		mem_wb.ctrl.valid <= 1'b0;
	end else if (!mem_stall) begin
		mem_wb <= mem_out;
	end
end

endmodule: cpu_datapath

// File: hdl/write_back_stage.sv
`timescale 1ns/1ps

module write_back_stage
(
	input logic clk,
	input logic reset,
	input lc3b_pkg::mem_wb_t mem_wb,
	output lc3b_pkg::lc3b_word write_data,
	output logic branch_enable
);

/* Condition codes in nzp order. */
logic [2:0] cc;
logic [2:0] next_cc;

assign write_data = mem_wb.result;

always_comb begin
	if (write_data[15])
		next_cc = 3'b100;
	else if (write_data == '0)
		next_cc = 3'b010;
	else
		next_cc = 3'b001;
end

always_ff @(posedge clk) begin
	if (reset) begin
		cc <= 3'b010;
	end else if (mem_wb.ctrl.valid && mem_wb.ctrl.load_cc) begin
		cc <= next_cc;
	end
end

assign branch_enable = mem_wb.ctrl.valid && mem_wb.ctrl.is_branch &&
                       |(mem_wb.ctrl.nzp & cc);

endmodule: write_back_stage

// File: hdl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage
(
	input logic clk,
	input logic reset,
	input lc3b_pkg::ex_mem_t ex_mem,
	input logic advance,
	input lc3b_pkg::lc3b_word dmem_rdata,
	input logic dmem_resp,
	output lc3b_pkg::lc3b_word dmem_address,
	output lc3b_pkg::lc3b_word dmem_wdata,
	output logic dmem_write,
	output logic dmem_action_stb,
	output logic dmem_action_cyc,
	output logic mem_stall,
	output lc3b_pkg::mem_wb_t mem_out
);

typedef enum logic [1:0] {
	mem_idle,
	mem_busy,
	mem_done
} mem_state_t;

mem_state_t state;
logic access;

assign access = ex_mem.ctrl.valid && (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write);

/* Done means the access held in EX/MEM has already completed. */
always_ff @(posedge clk) begin
	if (reset) begin
		state <= mem_idle;
	end else begin
		case (state)
			mem_idle: if (access) state <= mem_busy;
			mem_busy: if (dmem_resp) state <= advance ? mem_idle : mem_done;
			mem_done: if (advance) state <= mem_idle;
			default: state <= mem_idle;
		endcase
	end
end

assign dmem_action_stb = (state == mem_busy);
assign dmem_action_cyc = (state == mem_busy);
assign dmem_address = ex_mem.alu_result;
assign dmem_wdata = ex_mem.store_data;
assign dmem_write = ex_mem.ctrl.mem_write;

assign mem_stall = access && (state != mem_done) && !(state == mem_busy && dmem_resp);

always_comb begin
	mem_out.ctrl = ex_mem.ctrl;
	mem_out.result = ex_mem.ctrl.mem_read ? dmem_rdata : ex_mem.alu_result;
	mem_out.dest = ex_mem.dest;
	mem_out.branch_target = ex_mem.branch_target;
end

endmodule: memory_stage

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
(
	input lc3b_pkg::id_ex_t id_ex,
	input lc3b_pkg::lc3b_word ex_mem_result,
	input lc3b_pkg::lc3b_word wb_result,
	input logic [1:0] sr1_forward_sel,
	input logic [1:0] sr2_forward_sel,
	output lc3b_pkg::ex_mem_t executed
);

lc3b_pkg::lc3b_word sr1_value;
lc3b_pkg::lc3b_word sr2_value;
lc3b_pkg::lc3b_word operand_b;
lc3b_pkg::lc3b_word alu_out;
lc3b_pkg::lc3b_word mem_address;
logic mem_access;

always_comb begin
	case (sr1_forward_sel)
		2'b01: sr1_value = ex_mem_result;
		2'b10: sr1_value = wb_result;
		default: sr1_value = id_ex.sr1_value;
	endcase

	case (sr2_forward_sel)
		2'b01: sr2_value = ex_mem_result;
		2'b10: sr2_value = wb_result;
		default: sr2_value = id_ex.sr2_value;
	endcase
end

assign operand_b = id_ex.ctrl.use_imm ? id_ex.imm : sr2_value;

always_comb begin
	case (id_ex.ctrl.aluop)
		lc3b_pkg::alu_add: alu_out = sr1_value + operand_b;
		lc3b_pkg::alu_and: alu_out = sr1_value & operand_b;
		lc3b_pkg::alu_not: alu_out = ~sr1_value;
		default: alu_out = operand_b;
	endcase
end

/* Loads and stores form their address on a separate adder. */
assign mem_access = (id_ex.ctrl.opcode == lc3b_pkg::op_ldr) ||
                    (id_ex.ctrl.opcode == lc3b_pkg::op_str);
assign mem_address = sr1_value + id_ex.imm;

always_comb begin
	executed.ctrl = id_ex.ctrl;
	executed.alu_result = mem_access ? mem_address : alu_out;
	executed.store_data = sr2_value;
	executed.dest = id_ex.dest;
	executed.branch_target = id_ex.pc_plus2 + id_ex.br_offset;
end

endmodule: execute_stage

// File: hdl/execute_forward.sv
`timescale 1ns/1ps

module execute_forward
(
	input lc3b_pkg::id_ex_t id_ex,
	input lc3b_pkg::ex_mem_t ex_mem,
	input lc3b_pkg::mem_wb_t mem_wb,
	output logic [1:0] sr1_forward_sel,
	output logic [1:0] sr2_forward_sel,
	output logic load_use
);

logic ex_mem_writes;
logic mem_wb_writes;
logic sr1_used;
logic sr2_used;

assign ex_mem_writes = ex_mem.ctrl.valid && ex_mem.ctrl.load_regfile;
assign mem_wb_writes = mem_wb.ctrl.valid && mem_wb.ctrl.load_regfile;

/* Every instruction that writes a register or memory reads sr1. */
assign sr1_used = id_ex.ctrl.valid && (id_ex.ctrl.load_regfile || id_ex.ctrl.mem_write);
assign sr2_used = id_ex.ctrl.valid && id_ex.ctrl.uses_sr2;

/* 01 takes EX/MEM, 10 takes MEM/WB, 00 keeps the register file value. */
always_comb begin
	sr1_forward_sel = 2'b00;
	if (ex_mem_writes && ex_mem.dest == id_ex.sr1)
		sr1_forward_sel = 2'b01;
	else if (mem_wb_writes && mem_wb.dest == id_ex.sr1)
		sr1_forward_sel = 2'b10;

	sr2_forward_sel = 2'b00;
	if (id_ex.ctrl.uses_sr2 && ex_mem_writes && ex_mem.dest == id_ex.sr2)
		sr2_forward_sel = 2'b01;
	else if (id_ex.ctrl.uses_sr2 && mem_wb_writes && mem_wb.dest == id_ex.sr2)
		sr2_forward_sel = 2'b10;
end

assign load_use = ex_mem_writes && ex_mem.ctrl.mem_read &&
                  ((sr1_used && ex_mem.dest == id_ex.sr1) ||
                   (sr2_used && ex_mem.dest == id_ex.sr2));

endmodule: execute_forward

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
(
	input logic clk,
	input logic reset,
	input lc3b_pkg::if_id_t if_id,
	input lc3b_pkg::lc3b_reg write_register,
	input lc3b_pkg::lc3b_word write_data,
	input logic load_regfile,
	output lc3b_pkg::id_ex_t decoded
);

lc3b_pkg::lc3b_word regfile [8];
lc3b_pkg::lc3b_word instruction;
lc3b_pkg::lc3b_opcode opcode;
lc3b_pkg::lc3b_ctrl ctrl;
lc3b_pkg::lc3b_reg sr1;
lc3b_pkg::lc3b_reg sr2;
lc3b_pkg::lc3b_word imm5;
lc3b_pkg::lc3b_word offset6;
logic is_mem_op;

assign instruction = if_id.instruction;
assign opcode = lc3b_pkg::lc3b_opcode'(instruction[15:12]);
assign is_mem_op = (opcode == lc3b_pkg::op_ldr) || (opcode == lc3b_pkg::op_str);

/* STR reads its source register from the dest field. */
assign sr1 = instruction[8:6];
assign sr2 = (opcode == lc3b_pkg::op_str) ? instruction[11:9] : instruction[2:0];

assign imm5 = {{11{instruction[4]}}, instruction[4:0]};
assign offset6 = {{9{instruction[5]}}, instruction[5:0], 1'b0};

always_ff @(posedge clk) begin
	if (reset) begin
		for (int i = 0; i < 8; i++) begin
			regfile[i] <= '0;
		end
	end else if (load_regfile) begin
		regfile[write_register] <= write_data;
	end
end

/**************************************************/
/* Control decoder                                */
/**************************************************/

always_comb begin
	ctrl = '0;
	if (if_id.valid) begin
		ctrl.valid = 1'b1;
		ctrl.opcode = opcode;
		ctrl.aluop = lc3b_pkg::alu_pass;
		case (opcode)
			lc3b_pkg::op_add, lc3b_pkg::op_and: begin
				ctrl.aluop = (opcode == lc3b_pkg::op_add) ? lc3b_pkg::alu_add
				                                          : lc3b_pkg::alu_and;
				ctrl.use_imm = instruction[5];
				ctrl.uses_sr2 = !instruction[5];
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			lc3b_pkg::op_not: begin
				ctrl.aluop = lc3b_pkg::alu_not;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			lc3b_pkg::op_ldr: begin
				ctrl.use_imm = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.mem_read = 1'b1;
			end
			lc3b_pkg::op_str: begin
				ctrl.use_imm = 1'b1;
				ctrl.mem_write = 1'b1;
				ctrl.uses_sr2 = 1'b1;
			end
			lc3b_pkg::op_br: begin
				ctrl.is_branch = 1'b1;
				ctrl.nzp = instruction[11:9];
			end
			default: ;
		endcase
	end
end

/* Register reads see a write-back from the same cycle. */
always_comb begin
	decoded.ctrl = ctrl;
	decoded.pc_plus2 = if_id.pc_plus2;
	decoded.sr1 = sr1;
	decoded.sr2 = sr2;
	decoded.dest = instruction[11:9];
	decoded.sr1_value = (load_regfile && write_register == sr1) ? write_data : regfile[sr1];
	decoded.sr2_value = (load_regfile && write_register == sr2) ? write_data : regfile[sr2];
	decoded.imm = is_mem_op ? offset6 : imm5;
	decoded.br_offset = {{6{instruction[8]}}, instruction[8:0], 1'b0};
end

endmodule: decode_stage

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
(
	input logic clk,
	input logic reset,
	input logic advance,
	input logic branch_enable,
	input lc3b_pkg::lc3b_word branch_target,
	input lc3b_pkg::lc3b_word imem_rdata,
	input logic imem_resp,
	output lc3b_pkg::lc3b_word imem_address,
	output logic imem_action_stb,
	output logic imem_action_cyc,
	output lc3b_pkg::if_id_t fetch_out
);

lc3b_pkg::lc3b_word pc;
lc3b_pkg::lc3b_word redirect_pc;
lc3b_pkg::lc3b_word buffer;
logic buffer_valid;
logic drop;
logic resp_ok;

/* A request is open whenever no fetched instruction is waiting. */
assign imem_action_stb = !buffer_valid;
assign imem_action_cyc = !buffer_valid;
assign imem_address = pc;

assign resp_ok = imem_resp && !drop;

assign fetch_out.valid = buffer_valid || resp_ok;
assign fetch_out.pc_plus2 = pc + 16'd2;
assign fetch_out.instruction = buffer_valid ? buffer : imem_rdata;

always_ff @(posedge clk) begin
	if (reset) begin
		pc <= lc3b_pkg::reset_pc;
		buffer_valid <= 1'b0;
		drop <= 1'b0;
	end else if (branch_enable) begin
		buffer_valid <= 1'b0;
		/* The open request keeps its address until its response is thrown away. */
		if (imem_action_stb && !imem_resp) begin
			drop <= 1'b1;
			redirect_pc <= branch_target;
		end else begin
			drop <= 1'b0;
			pc <= branch_target;
		end
	end else if (drop) begin
		if (imem_resp) begin
			drop <= 1'b0;
			pc <= redirect_pc;
		end
	end else if (advance) begin
		buffer_valid <= 1'b0;
		pc <= pc + 16'd2;
	end else if (resp_ok) begin
		buffer_valid <= 1'b1;
		buffer <= imem_rdata;
	end
end

endmodule: fetch_stage

// File: hdl/lc3b_pkg.sv
package lc3b_pkg;

/**************************************************/
/* Basic types                                    */
/**************************************************/

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;

/* Opcodes not listed here run as no-ops. */
typedef enum logic [3:0] {
	op_br  = 4'b0000,
	op_add = 4'b0001,
	op_and = 4'b0101,
	op_ldr = 4'b0110,
	op_str = 4'b0111,
	op_not = 4'b1001
} lc3b_opcode;

typedef enum logic [1:0] {
	alu_add,
	alu_and,
	alu_not,
	alu_pass
} lc3b_aluop;

typedef struct packed {
	logic valid;
	lc3b_opcode opcode;
	lc3b_aluop aluop;
	logic use_imm;
	logic load_regfile;
	logic load_cc;
	logic mem_read;
	logic mem_write;
	logic is_branch;
	logic [2:0] nzp;
	logic uses_sr2;
} lc3b_ctrl;

/**************************************************/
/* Pipeline register payloads                     */
/**************************************************/

typedef struct packed {
	logic valid;
	lc3b_word pc_plus2;
	lc3b_word instruction;
} if_id_t;

typedef struct packed {
	lc3b_ctrl ctrl;
	lc3b_word pc_plus2;
	lc3b_reg sr1;
	lc3b_reg sr2;
	lc3b_reg dest;
	lc3b_word sr1_value;
	lc3b_word sr2_value;
	lc3b_word imm;
	lc3b_word br_offset;
} id_ex_t;

typedef struct packed {
	lc3b_ctrl ctrl;
	lc3b_word alu_result;
	lc3b_word store_data;
	lc3b_reg dest;
	lc3b_word branch_target;
} ex_mem_t;

typedef struct packed {
	lc3b_ctrl ctrl;
	lc3b_word result;
	lc3b_reg dest;
	lc3b_word branch_target;
} mem_wb_t;

localparam lc3b_word reset_pc = 16'h0000;

/* BR with nzp 000 never branches. */
localparam lc3b_word nop_instruction = 16'h0000;

endpackage: lc3b_pkg
